//--- display_pkg.sv
// frame display definitions
package display_pkg;

    // pixel coordinates for a 160x120 frame
    typedef logic [7:0] pixel_x_t;
    typedef logic [6:0] pixel_y_t;

    // 3-bit colour, one bit per channel
    typedef logic [2:0] colour_t;

    // painted tile is square
    localparam int tile_side = 8;

    // distance between cell origins
    localparam int cell_pitch_x = 10;
    localparam int cell_pitch_y = 15;

endpackage

//--- game_pkg.sv
// lane crossing game definitions
package game_pkg;

    // grid position
    typedef logic [3:0] col_t;
    typedef logic [2:0] row_t;

    // traffic lane index and pattern, bit 15 - col is column col
    typedef logic [1:0]  lane_t;
    typedef logic [15:0] lane_bits_t;

    typedef enum logic [2:0] {
        move_none,
        move_up,
        move_down,
        move_left,
        move_right
    } move_t;

    localparam int last_row       = 6;
    localparam int first_lane_row = 1;
    localparam int start_col      = 8;

    // lane patterns loaded at reset
    localparam lane_bits_t lane_seed_0 = 16'b1000_1101_1000_0000;
    localparam lane_bits_t lane_seed_1 = 16'b1100_0011_0001_0011;
    localparam lane_bits_t lane_seed_2 = 16'b0011_0111_0001_1001;
    localparam lane_bits_t lane_seed_3 = 16'b0110_0011_1001_1100;

    localparam display_pkg::colour_t frog_colour = 3'b111;
    localparam display_pkg::colour_t car_colour  = 3'b110;
    localparam display_pkg::colour_t road_colour = 3'b000;

    // clocks between two lane shifts
    localparam int step_cycles = 8192;

endpackage

//--- tile_if.sv
// tile paint request
interface tile_if;

    logic                  req;
    game_pkg::col_t        cell_col;
    game_pkg::row_t        cell_row;
    display_pkg::colour_t  fill;
    logic                  ack;
    // high while pixels are plotted
    logic                  busy;

    modport ctrl (
        output req, cell_col, cell_row, fill,
        input  ack, busy
    );

    modport painter (
        input  req, cell_col, cell_row, fill,
        output ack, busy
    );

endinterface

//--- scene_control.sv
// game sequencing FSM
module scene_control (
    input  logic            fastclock,
    input  logic            resetn,
    input  logic            key_up,
    input  logic            key_down,
    input  logic            key_left,
    input  logic            key_right,
    tile_if.ctrl            paint,
    output game_pkg::move_t step,
    output logic            return_to_start,
    input  game_pkg::col_t  frog_col,
    input  game_pkg::row_t  frog_row,
    output game_pkg::lane_t query_lane,
    output game_pkg::col_t  query_col,
    input  logic            query_occupied,
    input  logic            frog_hit,
    input  logic            lane_step
);

    typedef enum logic [2:0] {
        s_idle,
        s_step,
        s_check,
        s_lane_hit,
        s_lane,
        s_frog,
        s_req,
        s_done
    } state_t;

    state_t                state;
    state_t                after;
    game_pkg::move_t       move_q;
    game_pkg::move_t       key_move;
    logic                  pending;
    logic                  armed;
    game_pkg::lane_t       lane_idx;
    game_pkg::col_t        col_idx;
    logic                  req_q;
    game_pkg::col_t        cell_col_q;
    game_pkg::row_t        cell_row_q;
    display_pkg::colour_t  fill_q;
    logic                  any_key;
    logic                  redraw_due;
    logic                  start_move;
    logic                  last_tile;

    // up wins over down, left and right
    always_comb begin
        if (key_up)
            key_move = game_pkg::move_up;
        else if (key_down)
            key_move = game_pkg::move_down;
        else if (key_left)
            key_move = game_pkg::move_left;
        else if (key_right)
            key_move = game_pkg::move_right;
        else
            key_move = game_pkg::move_none;
    end

    assign any_key    = key_up | key_down | key_left | key_right;
    assign redraw_due = pending | lane_step;
    assign start_move = (state == s_idle) && !redraw_due && armed && any_key;
    assign last_tile  = (lane_idx == 2'd3) && (col_idx == 4'd15);

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            state    <= s_idle;
            after    <= s_idle;
            pending  <= 1'b0;
            armed    <= 1'b1;
            lane_idx <= '0;
            col_idx  <= '0;
            req_q    <= 1'b0;
        end else begin
            // a lane step during a move is served afterwards
            if ((state == s_idle) && redraw_due)
                pending <= 1'b0;
            else if (lane_step)
                pending <= 1'b1;

            // one move per press
            if (start_move)
                armed <= 1'b0;
            else if (!any_key)
                armed <= 1'b1;

            case (state)
                s_idle: begin
                    if (redraw_due) begin
                        state <= s_lane_hit;
                    end else if (start_move) begin
                        // erase tile goes first
                        req_q <= 1'b1;
                        after <= s_step;
                        state <= s_req;
                    end
                end
                s_step:     state <= s_check;
                s_check:    state <= s_frog;
                s_lane_hit: begin
                    lane_idx <= '0;
                    col_idx  <= '0;
                    state    <= s_lane;
                end
                s_lane: begin
                    req_q   <= 1'b1;
                    col_idx <= col_idx + 1'b1;
                    if (col_idx == 4'd15)
                        lane_idx <= lane_idx + 1'b1;
                    after <= last_tile ? s_frog : s_lane;
                    state <= s_req;
                end
                s_frog: begin
                    req_q <= 1'b1;
                    after <= s_idle;
                    state <= s_req;
                end
                s_req: begin
                    if (paint.ack) begin
                        req_q <= 1'b0;
                        state <= s_done;
                    end
                end
                s_done: begin
                    if (!paint.ack && !paint.busy)
                        state <= after;
                end
                default: state <= s_idle;
            endcase
        end
    end

    // tile cell and fill held stable while req is up
    always_ff @(posedge fastclock) begin
        if (start_move) begin
            move_q     <= key_move;
            cell_col_q <= frog_col;
            cell_row_q <= frog_row;
            fill_q     <= game_pkg::road_colour;
        end else if (state == s_frog) begin
            cell_col_q <= frog_col;
            cell_row_q <= frog_row;
            fill_q     <= game_pkg::frog_colour;
        end else if (state == s_lane) begin
            cell_col_q <= col_idx;
            cell_row_q <= game_pkg::row_t'(lane_idx) + game_pkg::row_t'(game_pkg::first_lane_row);
            fill_q     <= query_occupied ? game_pkg::car_colour : game_pkg::road_colour;
        end
    end

    assign paint.req      = req_q;
    assign paint.cell_col = cell_col_q;
    assign paint.cell_row = cell_row_q;
    assign paint.fill     = fill_q;

    assign step            = (state == s_step) ? move_q : game_pkg::move_none;
    assign return_to_start = ((state == s_check) || (state == s_lane_hit)) && frog_hit;
    assign query_lane      = lane_idx;
    assign query_col       = col_idx;

endmodule

//--- frog_position.sv
// frog cell register
module frog_position (
    input  logic            fastclock,
    input  logic            resetn,
    input  game_pkg::move_t step,
    input  logic            return_to_start,
    output game_pkg::col_t  frog_col,
    output game_pkg::row_t  frog_row,
    output logic            win
);

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            frog_col <= game_pkg::col_t'(game_pkg::start_col);
            frog_row <= game_pkg::row_t'(game_pkg::last_row);
        end else if (return_to_start) begin
            frog_col <= game_pkg::col_t'(game_pkg::start_col);
            frog_row <= game_pkg::row_t'(game_pkg::last_row);
        end else begin
            // moves off the grid are dropped
            case (step)
                game_pkg::move_up: begin
                    if (frog_row != 3'd0)
                        frog_row <= frog_row - 1'b1;
                end
                game_pkg::move_down: begin
                    if (frog_row != game_pkg::row_t'(game_pkg::last_row))
                        frog_row <= frog_row + 1'b1;
                end
                game_pkg::move_left: begin
                    if (frog_col != 4'd0)
                        frog_col <= frog_col - 1'b1;
                end
                game_pkg::move_right: begin
                    if (frog_col != 4'd15)
                        frog_col <= frog_col + 1'b1;
                end
                default: begin
                    frog_col <= frog_col;
                end
            endcase
        end
    end

    // top row reached
    assign win = (frog_row == 3'd0);

endmodule

//--- traffic_lanes.sv
// rotating traffic lanes
module traffic_lanes (
    input  logic            fastclock,
    input  logic            resetn,
    input  game_pkg::col_t  frog_col,
    input  game_pkg::row_t  frog_row,
    input  game_pkg::lane_t query_lane,
    input  game_pkg::col_t  query_col,
    output logic            query_occupied,
    output logic            frog_hit,
    output logic            lane_step
);

    localparam int step_w = $clog2(game_pkg::step_cycles);
    localparam logic [step_w-1:0] step_last = step_w'(game_pkg::step_cycles - 1);

    game_pkg::lane_bits_t lanes [4];
    logic [step_w-1:0]    step_count;
    game_pkg::row_t       frog_rel;
    game_pkg::lane_t      frog_lane;
    logic                 frog_in_lane;

    function automatic logic cell_bit(input game_pkg::lane_bits_t bits,
                                      input game_pkg::col_t col);
        return bits[4'd15 - col];
    endfunction

    assign lane_step = (step_count == step_last);

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            step_count <= '0;
            lanes[0]   <= game_pkg::lane_seed_0;
            lanes[1]   <= game_pkg::lane_seed_1;
            lanes[2]   <= game_pkg::lane_seed_2;
            lanes[3]   <= game_pkg::lane_seed_3;
        end else if (lane_step) begin
            step_count <= '0;
            // all lanes shift left together
            for (int i = 0; i < 4; i++)
                lanes[i] <= {lanes[i][14:0], lanes[i][15]};
        end else begin
            step_count <= step_count + 1'b1;
        end
    end

    assign query_occupied = cell_bit(lanes[query_lane], query_col);

    // row 0 wraps past the lane range
    assign frog_rel     = frog_row - game_pkg::row_t'(game_pkg::first_lane_row);
    assign frog_in_lane = (frog_rel < 3'd4);
    assign frog_lane    = game_pkg::lane_t'(frog_rel);
    assign frog_hit     = frog_in_lane && cell_bit(lanes[frog_lane], frog_col);

endmodule

//--- tile_painter.sv
// cell tile pixel scanner
module tile_painter (
    input  logic                  fastclock,
    input  logic                  resetn,
    tile_if.painter               paint,
    output display_pkg::pixel_x_t pixel_x,
    output display_pkg::pixel_y_t pixel_y,
    output display_pkg::colour_t  pixel_colour,
    output logic                  plot
);

    typedef enum logic [1:0] {
        p_idle,
        p_plot,
        p_ack
    } state_t;

    localparam logic [5:0] scan_last = 6'(display_pkg::tile_side * display_pkg::tile_side - 1);

    state_t                state;
    logic [5:0]            scan;
    display_pkg::pixel_x_t origin_x;
    display_pkg::pixel_y_t origin_y;
    display_pkg::colour_t  fill_q;

    always_ff @(posedge fastclock or negedge resetn) begin
        if (!resetn) begin
            state <= p_idle;
            scan  <= '0;
        end else begin
            case (state)
                p_idle: begin
                    if (paint.req) begin
                        state <= p_plot;
                        scan  <= '0;
                    end
                end
                p_plot: begin
                    scan <= scan + 1'b1;
                    if (scan == scan_last)
                        state <= p_ack;
                end
                p_ack: begin
                    // hold ack until req drops
                    if (!paint.req)
                        state <= p_idle;
                end
                default: state <= p_idle;
            endcase
        end
    end

    // cell origin latched on an accepted req
    always_ff @(posedge fastclock) begin
        if ((state == p_idle) && paint.req) begin
            origin_x <= display_pkg::pixel_x_t'(paint.cell_col * display_pkg::cell_pitch_x);
            origin_y <= display_pkg::pixel_y_t'(paint.cell_row * display_pkg::cell_pitch_y);
            fill_q   <= paint.fill;
        end
    end

    // low bits step across, high bits step down
    assign pixel_x      = origin_x + display_pkg::pixel_x_t'(scan[2:0]);
    assign pixel_y      = origin_y + display_pkg::pixel_y_t'(scan[5:3]);
    assign pixel_colour = fill_q;
    assign plot         = (state == p_plot);

    assign paint.busy = plot;
    assign paint.ack  = (state == p_ack);

endmodule

//--- frogger_top.sv
// lane crossing game top
module frogger_top (
    input  logic                  fastclock,
    input  logic                  resetn,
    input  logic                  key_up,
    input  logic                  key_down,
    input  logic                  key_left,
    input  logic                  key_right,
    output display_pkg::pixel_x_t pixel_x,
    output display_pkg::pixel_y_t pixel_y,
    output display_pkg::colour_t  pixel_colour,
    output logic                  plot,
    output logic                  win
);

    tile_if paint_bus ();

    game_pkg::move_t step;
    logic            return_to_start;
    game_pkg::col_t  frog_col;
    game_pkg::row_t  frog_row;
    game_pkg::lane_t query_lane;
    game_pkg::col_t  query_col;
    logic            query_occupied;
    logic            frog_hit;
    logic            lane_step;

    scene_control u_scene_control (
        .fastclock       (fastclock),
        .resetn          (resetn),
        .key_up          (key_up),
        .key_down        (key_down),
        .key_left        (key_left),
        .key_right       (key_right),
        .paint           (paint_bus.ctrl),
        .step            (step),
        .return_to_start (return_to_start),
        .frog_col        (frog_col),
        .frog_row        (frog_row),
        .query_lane      (query_lane),
        .query_col       (query_col),
        .query_occupied  (query_occupied),
        .frog_hit        (frog_hit),
        .lane_step       (lane_step)
    );

    frog_position u_frog_position (
        .fastclock       (fastclock),
        .resetn          (resetn),
        .step            (step),
        .return_to_start (return_to_start),
        .frog_col        (frog_col),
        .frog_row        (frog_row),
        .win             (win)
    );

    traffic_lanes u_traffic_lanes (
        .fastclock      (fastclock),
        .resetn         (resetn),
        .frog_col       (frog_col),
        .frog_row       (frog_row),
        .query_lane     (query_lane),
        .query_col      (query_col),
        .query_occupied (query_occupied),
        .frog_hit       (frog_hit),
        .lane_step      (lane_step)
    );

    tile_painter u_tile_painter (
        .fastclock    (fastclock),
        .resetn       (resetn),
        .paint        (paint_bus.painter),
        .pixel_x      (pixel_x),
        .pixel_y      (pixel_y),
        .pixel_colour (pixel_colour),
        .plot         (plot)
    );

endmodule

//--- frogger_checker.sv
// tile handshake assertions
module frogger_checker (
    input logic                  fastclock,
    input logic                  resetn,
    input logic                  req,
    input logic                  ack,
    input logic                  plot,
    input display_pkg::pixel_x_t pixel_x,
    input display_pkg::pixel_y_t pixel_y
);

    int fail_count = 0;

    // pixels only inside an open request
    plot_in_req: assert property (@(posedge fastclock) disable iff (!resetn)
        plot |-> (req && !ack))
    else begin
        fail_count++;
        $error("plot high outside an open tile request");
    end

    ack_after_req: assert property (@(posedge fastclock) disable iff (!resetn)
        $rose(ack) |-> $past(req))
    else begin
        fail_count++;
        $error("ack raised with no request before it");
    end

    pixel_on_frame: assert property (@(posedge fastclock) disable iff (!resetn)
        plot |-> ((pixel_x < 8'd160) && (pixel_y < 7'd120)))
    else begin
        fail_count++;
        $error("plotted pixel lies outside the 160x120 frame");
    end

endmodule

bind tile_painter frogger_checker u_checker (
    .fastclock (fastclock),
    .resetn    (resetn),
    .req       (paint.req),
    .ack       (paint.ack),
    .plot      (plot),
    .pixel_x   (pixel_x),
    .pixel_y   (pixel_y)
);

//--- frogger_tb.sv
// lane crossing game testbench
module frogger_tb;

    logic                  fastclock;
    logic                  resetn;
    logic                  key_up;
    logic                  key_down;
    logic                  key_left;
    logic                  key_right;
    display_pkg::pixel_x_t pixel_x;
    display_pkg::pixel_y_t pixel_y;
    display_pkg::colour_t  pixel_colour;
    logic                  plot;
    logic                  win;

    // one row per operation
    string                 t_name [$];
    game_pkg::move_t       t_key [$];
    game_pkg::col_t        t_col [$];
    game_pkg::row_t        t_row [$];
    logic                  t_win [$];

    game_pkg::lane_bits_t  model_seed [4];
    int                    redraws;
    // expected frog cell before the next operation
    game_pkg::col_t        frog_col;
    game_pkg::row_t        frog_row;
    int                    value_errors;
    int                    other_errors;
    logic                  aborted;

    frogger_top dut (
        .fastclock    (fastclock),
        .resetn       (resetn),
        .key_up       (key_up),
        .key_down     (key_down),
        .key_left     (key_left),
        .key_right    (key_right),
        .pixel_x      (pixel_x),
        .pixel_y      (pixel_y),
        .pixel_colour (pixel_colour),
        .plot         (plot),
        .win          (win)
    );

    initial begin
        fastclock = 1'b0;
        forever #4 fastclock = ~fastclock;
    end

    task automatic add_case(input string name, input game_pkg::move_t key,
                            input int col, input int row, input logic w);
        t_name.push_back(name);
        t_key.push_back(key);
        t_col.push_back(game_pkg::col_t'(col));
        t_row.push_back(game_pkg::row_t'(row));
        t_win.push_back(w);
    endtask

    task automatic fill_table();
        add_case("first_step", game_pkg::move_none, 8, 6, 1'b0);
        add_case("edge_down", game_pkg::move_down, 8, 6, 1'b0);
        add_case("up_row5", game_pkg::move_up, 8, 5, 1'b0);
        add_case("up_lane3", game_pkg::move_up, 8, 4, 1'b0);
        add_case("up_lane2", game_pkg::move_up, 8, 3, 1'b0);
        add_case("up_lane1", game_pkg::move_up, 8, 2, 1'b0);
        add_case("up_lane0", game_pkg::move_up, 8, 1, 1'b0);
        add_case("up_goal", game_pkg::move_up, 8, 0, 1'b1);
        add_case("down_from_goal", game_pkg::move_down, 8, 1, 1'b0);
        add_case("left_into_car", game_pkg::move_left, 8, 6, 1'b0);
        add_case("up_again", game_pkg::move_up, 8, 5, 1'b0);
        add_case("right_row5", game_pkg::move_right, 9, 5, 1'b0);
        add_case("up_onto_lane3", game_pkg::move_up, 9, 4, 1'b0);
        // car reaches column 9 of lane 3 on this step
        add_case("lane_hit", game_pkg::move_none, 8, 6, 1'b0);
        for (int c = 7; c >= 0; c--)
            add_case($sformatf("walk_left_%0d", c), game_pkg::move_left, c, 6, 1'b0);
        add_case("edge_left", game_pkg::move_left, 0, 6, 1'b0);
        add_case("third_step", game_pkg::move_none, 0, 6, 1'b0);
    endtask

    function automatic display_pkg::pixel_x_t origin_x(input game_pkg::col_t col);
        return display_pkg::pixel_x_t'(int'(col) * display_pkg::cell_pitch_x);
    endfunction

    function automatic display_pkg::pixel_y_t origin_y(input game_pkg::row_t row);
        return display_pkg::pixel_y_t'(int'(row) * display_pkg::cell_pitch_y);
    endfunction

    // cars move one column left per redraw
    function automatic logic model_car(input int lane, input int col);
        return model_seed[lane][15 - ((col + redraws) % 16)];
    endfunction

    task automatic check_pixel(input string name,
                               input display_pkg::pixel_x_t exp_x,
                               input display_pkg::pixel_y_t exp_y,
                               input display_pkg::colour_t exp_c,
                               input display_pkg::pixel_x_t act_x,
                               input display_pkg::pixel_y_t act_y,
                               input display_pkg::colour_t act_c);
        if ((exp_x !== act_x) || (exp_y !== act_y) || (exp_c !== act_c)) begin
            value_errors++;
            $display("** Error %s: pixel expected (%0d,%0d) %b, actual (%0d,%0d) %b",
                     name, exp_x, exp_y, exp_c, act_x, act_y, act_c);
        end
    endtask

    task automatic check_cell(input string name,
                              input game_pkg::col_t exp_col, input game_pkg::row_t exp_row,
                              input game_pkg::col_t act_col, input game_pkg::row_t act_row);
        if ((exp_col !== act_col) || (exp_row !== act_row)) begin
            value_errors++;
            $display("** Error %s: frog cell expected (%0d,%0d), actual (%0d,%0d)",
                     name, exp_col, exp_row, act_col, act_row);
        end
    endtask

    task automatic check_flag(input string name, input logic exp_f, input logic act_f);
        if (exp_f !== act_f) begin
            value_errors++;
            $display("** Error %s: win expected %b, actual %b", name, exp_f, act_f);
        end
    endtask

    task automatic next_cycle();
        @(posedge fastclock);
        #1;
    endtask

    task automatic drive_key(input game_pkg::move_t key);
        key_up    = (key == game_pkg::move_up);
        key_down  = (key == game_pkg::move_down);
        key_left  = (key == game_pkg::move_left);
        key_right = (key == game_pkg::move_right);
    endtask

    task automatic wait_plot(input int limit, output int waited);
        waited = 0;
        while (!plot && (waited < limit)) begin
            next_cycle();
            waited++;
        end
    endtask

    // collects one tile of 64 plots and takes origin and fill from its first pixel
    task automatic get_tile(input string name, input int limit,
                            output display_pkg::pixel_x_t ox,
                            output display_pkg::pixel_y_t oy,
                            output display_pkg::colour_t fill);
        int   waited;
        logic gap;
        gap  = 1'b0;
        ox   = '0;
        oy   = '0;
        fill = '0;
        wait_plot(limit, waited);
        if (!plot) begin
            $display("%s: no tile was plotted within %0d cycles", name, waited);
            other_errors++;
            aborted = 1'b1;
        end else begin
            ox   = pixel_x;
            oy   = pixel_y;
            fill = pixel_colour;
            if (((ox % display_pkg::cell_pitch_x) != 0) ||
                ((oy % display_pkg::cell_pitch_y) != 0)) begin
                $display("%s: tile starts at (%0d,%0d), not at a cell origin", name, ox, oy);
                other_errors++;
            end
            for (int i = 0; i < 64; i++) begin
                if (!plot)
                    gap = 1'b1;
                else
                    check_pixel(name,
                        display_pkg::pixel_x_t'(int'(ox) + (i % display_pkg::tile_side)),
                        display_pkg::pixel_y_t'(int'(oy) + (i / display_pkg::tile_side)),
                        fill, pixel_x, pixel_y, pixel_colour);
                next_cycle();
            end
            if (gap || plot) begin
                $display("%s: plot was not high for exactly 64 cycles", name);
                other_errors++;
            end
        end
    endtask

    task automatic frog_tile(input int n);
        display_pkg::pixel_x_t ox;
        display_pkg::pixel_y_t oy;
        display_pkg::colour_t  fill;
        game_pkg::col_t        act_col;
        game_pkg::row_t        act_row;
        get_tile(t_name[n], 100, ox, oy, fill);
        if (!aborted) begin
            check_pixel(t_name[n], origin_x(t_col[n]), origin_y(t_row[n]),
                        game_pkg::frog_colour, ox, oy, fill);
            // frog cell is where its tile landed
            act_col = game_pkg::col_t'(ox / display_pkg::cell_pitch_x);
            act_row = game_pkg::row_t'(oy / display_pkg::cell_pitch_y);
            check_cell(t_name[n], t_col[n], t_row[n], act_col, act_row);
        end
        frog_col = t_col[n];
        frog_row = t_row[n];
    endtask

    task automatic run_move(input int n);
        display_pkg::pixel_x_t ox;
        display_pkg::pixel_y_t oy;
        display_pkg::colour_t  fill;
        drive_key(t_key[n]);
        get_tile(t_name[n], 200, ox, oy, fill);
        if (!aborted) begin
            // old cell cleared to road first
            check_pixel(t_name[n], origin_x(frog_col), origin_y(frog_row),
                        game_pkg::road_colour, ox, oy, fill);
            frog_tile(n);
        end
        drive_key(game_pkg::move_none);
    endtask

    task automatic run_redraw(input int n);
        display_pkg::pixel_x_t ox;
        display_pkg::pixel_y_t oy;
        display_pkg::colour_t  fill;
        display_pkg::colour_t  exp_fill;
        int                    limit;
        redraws++;
        for (int lane = 0; lane < 4; lane++) begin
            for (int col = 0; col < 16; col++) begin
                limit = ((lane == 0) && (col == 0)) ? game_pkg::step_cycles + 200 : 100;
                if (!aborted)
                    get_tile(t_name[n], limit, ox, oy, fill);
                if (!aborted) begin
                    exp_fill = model_car(lane, col) ? game_pkg::car_colour
                                                    : game_pkg::road_colour;
                    check_pixel(t_name[n], origin_x(game_pkg::col_t'(col)),
                                origin_y(game_pkg::row_t'(lane + game_pkg::first_lane_row)),
                                exp_fill, ox, oy, fill);
                end
            end
        end
        if (!aborted)
            frog_tile(n);
    endtask

    initial begin
        int waited;
        int assert_fails;
        resetn        = 1'b0;
        drive_key(game_pkg::move_none);
        value_errors  = 0;
        other_errors  = 0;
        aborted       = 1'b0;
        redraws       = 0;
        frog_col      = game_pkg::col_t'(game_pkg::start_col);
        frog_row      = game_pkg::row_t'(game_pkg::last_row);
        model_seed[0] = game_pkg::lane_seed_0;
        model_seed[1] = game_pkg::lane_seed_1;
        model_seed[2] = game_pkg::lane_seed_2;
        model_seed[3] = game_pkg::lane_seed_3;
        fill_table();
        repeat (10) @(posedge fastclock);
        #1;
        resetn = 1'b1;

        // screen stays quiet until the first lane step
        wait_plot(game_pkg::step_cycles - 8, waited);
        if (plot) begin
            $display("a pixel was plotted %0d cycles after reset, before any lane step", waited);
            other_errors++;
        end

        for (int n = 0; (n < t_name.size()) && !aborted; n++) begin
            if (t_key[n] == game_pkg::move_none)
                run_redraw(n);
            else
                run_move(n);
            if (!aborted)
                check_flag(t_name[n], t_win[n], win);
            next_cycle();
        end

        assert_fails = dut.u_tile_painter.u_checker.fail_count;
        $display("errors: %0d value, %0d other, %0d assertion",
                 value_errors, other_errors, assert_fails);
        if ((value_errors == 0) && (other_errors == 0) && (assert_fails == 0)) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- frogger_top.f
display_pkg.sv
game_pkg.sv
tile_if.sv
scene_control.sv
frog_position.sv
traffic_lanes.sv
tile_painter.sv
frogger_top.sv
frogger_checker.sv
frogger_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= frogger_tb
FILELIST   ?= frogger_top.f
OBJ_DIR    ?= obj_dir
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
SIM_ARGS   ?= +verilator+error+limit+1000
PASS_TEXT  ?= RESULT: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
